// File: src/spritePkg.sv
// Screen geometry, pixel types, state and direction encodings and sprite shape for the sprite mover
package spritePkg;

	//**********************************************************************
	// Geometry
	//**********************************************************************
	localparam int SCREEN_W    = 160;                       // Framebuffer columns
	localparam int SCREEN_H    = 120;                       // Framebuffer rows
	localparam int SPRITE_SIZE = 13;                        // Box edge in pixels
	localparam int MAX_X       = SCREEN_W - SPRITE_SIZE;    // Rightmost legal corner, 147
	localparam int MAX_Y       = SCREEN_H - SPRITE_SIZE;    // Lowest legal corner, 107
	localparam int START_X     = 64;
	localparam int START_Y     = 54;
	localparam int PIXEL_COUNT = SPRITE_SIZE * SPRITE_SIZE; // One full pass, 169

	// Pixel port types
	typedef logic [7:0] xCoordT;
	typedef logic [6:0] yCoordT;
	typedef logic [3:0] spriteIdxT;    // Offset inside the box
	typedef logic [2:0] colourT;       // One bit per RGB channel

	localparam colourT COLOUR_BLACK  = 3'd0;
	localparam colourT COLOUR_SPRITE = 3'd5;   // Red plus blue

	// Sequencer states
	typedef enum logic [2:0] {
		sClear,    // Black pass over the start box
		sDraw,     // Sprite pass at the current corner
		sWait,     // Idle until a tick with a direction
		sErase,    // Black pass at the old corner
		sMove      // Single step cycle
	} fsmStateT;

	// Move opcodes decoded from the switches
	typedef enum logic [2:0] {
		dirNone,
		dirRight,
		dirUp,
		dirDown,
		dirLeft
	} dirT;

	//**********************************************************************
	// Sprite shape, first and last lit column per row
	//**********************************************************************
	typedef struct packed {
		spriteIdxT firstCol;
		spriteIdxT lastCol;
	} rowSpanT;

	localparam rowSpanT spriteRowSpan [SPRITE_SIZE] = '{
		'{4'd5, 4'd7},     // Row 0, top cap
		'{4'd3, 4'd10},
		'{4'd2, 4'd11},
		'{4'd1, 4'd12},
		'{4'd1, 4'd12},
		'{4'd0, 4'd12},    // Rows 5 to 7 span the whole box
		'{4'd0, 4'd12},
		'{4'd0, 4'd12},
		'{4'd1, 4'd12},
		'{4'd1, 4'd12},
		'{4'd2, 4'd11},
		'{4'd3, 4'd10},
		'{4'd5, 4'd7}      // Row 12, bottom cap
	};

endpackage

// File: src/scanIf.sv
// Scan request channel between the sequencer FSM and the pixel scanner
interface scanIf import spritePkg::*; ();

	logic   start;    // One-cycle request, only while the scanner is idle
	logic   erase;    // 1 for a black pass
	xCoordT baseX;    // Box corner, sampled with start
	yCoordT baseY;
	logic   done;     // One cycle, together with the last pixel

	// Requesting side
	modport fsm (
		output start,
		output erase,
		input  done
	);

	// Pixel side
	modport scanner (
		input  start,
		input  erase,
		input  baseX,
		input  baseY,
		output done
	);

	// Corner comes straight from the position register at the top level

endinterface

// File: src/moveTimer.sv
// Movement tick generator; one-cycle enable every TICK_DIV clocks of CLOCK_50
module moveTimer #(
	parameter int TICK_DIV = 6_500_000    // Clocks per movement tick
) (
	input  logic CLOCK_50,
	input  logic resetn,
	output logic tick
);

	localparam int CNT_W = $clog2(TICK_DIV);             // Holds TICK_DIV - 1
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_DIV - 1);

	logic [CNT_W-1:0] count;

	// Down-counter, tick registered on the zero cycle
	// First tick lands TICK_DIV cycles after reset release
	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn) begin
			count <= RELOAD;
			tick  <= 1'b0;
		end else begin
			if (count == '0) begin
				count <= RELOAD;    // Restart the period
				tick  <= 1'b1;
			end else begin
				count <= count - 1'b1;
				tick  <= 1'b0;
			end
		end
	end

endmodule

// File: src/spriteFsm.sv
// Sequencer for the sprite mover; orders clear, draw, wait, erase and move and issues scan requests
module spriteFsm import spritePkg::*; (
	input  logic       CLOCK_50,
	input  logic       resetn,
	input  logic       tick,         // Movement enable from moveTimer
	input  logic [3:0] direction,    // Bit 0 right, 1 up, 2 down, 3 left
	scanIf.fsm         scan,
	output logic       step,         // One cycle, in sMove
	output dirT        stepDir       // Held from the tick until the step
);

	fsmStateT state;
	logic     passIssued;    // Start already sent for the pass of this state
	dirT      reqDir;        // Switches decoded this cycle
	logic     moveReq;       // Accepted tick in sWait

	//**********************************************************************
	// Direction decode
	//**********************************************************************
	always_comb begin
		case (direction)
			4'b0001: reqDir = dirRight;
			4'b0010: reqDir = dirUp;
			4'b0100: reqDir = dirDown;
			4'b1000: reqDir = dirLeft;
			default: reqDir = dirNone;    // None set or several at once
		endcase
	end

	assign moveReq = (state == sWait) && tick && (reqDir != dirNone);

	// Erase pass starts in the tick cycle itself
	// Clear and draw passes start in the first cycle of their state
	assign scan.start = moveReq || (((state == sClear) || (state == sDraw)) && !passIssued);
	assign scan.erase = (state != sDraw);    // Only looked at with start
	assign step       = (state == sMove);

	//**********************************************************************
	// State register
	//**********************************************************************
	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn) begin
			state      <= sClear;
			passIssued <= 1'b0;
			stepDir    <= dirNone;
		end else begin
			case (state)
				sClear: begin
					if (scan.done) begin
						state      <= sDraw;    // Draw request goes out next cycle
						passIssued <= 1'b0;
					end else if (!passIssued) begin
						passIssued <= 1'b1;
					end
				end
				sDraw: begin
					if (scan.done) begin
						state <= sWait;
					end else if (!passIssued) begin
						passIssued <= 1'b1;
					end
				end
				sWait: begin
					if (moveReq) begin
						state   <= sErase;
						stepDir <= reqDir;    // Kept for the step after the erase
					end
				end
				sErase: begin
					if (scan.done) begin
						state <= sMove;
					end
				end
				sMove: begin
					state      <= sDraw;    // Corner settles during the first sDraw cycle
					passIssued <= 1'b0;
				end
				default: begin
					state      <= sClear;
					passIssued <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: src/spritePosition.sv
// Sprite top-left corner register; one-pixel moves clamped to the screen edges
module spritePosition import spritePkg::*; (
	input  logic   CLOCK_50,
	input  logic   resetn,
	input  logic   step,       // One-cycle move request
	input  dirT    stepDir,
	output xCoordT posX,
	output yCoordT posY
);

	localparam xCoordT LIMIT_X = xCoordT'(MAX_X);
	localparam yCoordT LIMIT_Y = yCoordT'(MAX_Y);

	// New corner visible one cycle after step
	// A step against an edge keeps the corner
	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn) begin
			posX <= xCoordT'(START_X);
			posY <= yCoordT'(START_Y);
		end else if (step) begin
			case (stepDir)
				dirRight: begin
					if (posX < LIMIT_X) posX <= posX + 1'b1;
				end
				dirLeft: begin
					if (posX > '0) posX <= posX - 1'b1;
				end
				dirUp: begin
					if (posY > '0) posY <= posY - 1'b1;    // Row 0 is the top
				end
				dirDown: begin
					if (posY < LIMIT_Y) posY <= posY + 1'b1;
				end
				default: begin
					posX <= posX;    // dirNone, no move
				end
			endcase
		end
	end

endmodule

// File: src/spriteScanner.sv
// Pixel scanner; walks the 13x13 box row by row and emits one pixel write per cycle
module spriteScanner import spritePkg::*; (
	input  logic   CLOCK_50,
	input  logic   resetn,
	scanIf.scanner scan,
	output xCoordT pixelX,
	output yCoordT pixelY,
	output colourT pixelColour,
	output logic   plot
);

	localparam spriteIdxT LAST_IDX = spriteIdxT'(SPRITE_SIZE - 1);

	// Captured request
	xCoordT    baseXR;
	yCoordT    baseYR;
	logic      eraseR;
	// Walk counters hold the next pixel and rest at zero when idle
	logic      busy;
	spriteIdxT col;
	spriteIdxT row;

	// Pixel being produced this cycle
	xCoordT    curBaseX;
	yCoordT    curBaseY;
	logic      curErase;
	spriteIdxT curCol;
	spriteIdxT curRow;
	logic      active;
	logic      lastPixel;
	logic      inSpan;
	colourT    curColour;

	//**********************************************************************
	// Current pixel select
	//**********************************************************************
	// In the start cycle the request is used directly, so pixel 0 leaves on the next edge
	assign active   = scan.start || busy;
	assign curBaseX = busy ? baseXR : scan.baseX;
	assign curBaseY = busy ? baseYR : scan.baseY;
	assign curErase = busy ? eraseR : scan.erase;
	assign curCol   = col;    // Already zero for pixel 0
	assign curRow   = row;

	assign lastPixel = (curCol == LAST_IDX) && (curRow == LAST_IDX);

	// Colour from the row span table
	assign inSpan    = (curCol >= spriteRowSpan[curRow].firstCol) &&
	                   (curCol <= spriteRowSpan[curRow].lastCol);
	assign curColour = (curErase || !inSpan) ? COLOUR_BLACK : COLOUR_SPRITE;

	// Request and pixel payload
	always_ff @(posedge CLOCK_50) begin
		if (scan.start) begin
			baseXR <= scan.baseX;
			baseYR <= scan.baseY;
			eraseR <= scan.erase;
		end
		if (active) begin
			pixelX      <= curBaseX + xCoordT'(curCol);
			pixelY      <= curBaseY + yCoordT'(curRow);
			pixelColour <= curColour;
		end
	end

	// Walk control, plot and done
	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn) begin
			busy      <= 1'b0;
			col       <= '0;
			row       <= '0;
			plot      <= 1'b0;
			scan.done <= 1'b0;
		end else begin
			plot      <= active;
			scan.done <= active && lastPixel;    // Same cycle as the final write
			if (active) begin
				if (lastPixel) begin
					busy <= 1'b0;    // Idle again during the done cycle
					col  <= '0;
					row  <= '0;
				end else if (curCol == LAST_IDX) begin
					busy <= 1'b1;
					col  <= '0;    // Wrap to next row
					row  <= curRow + 1'b1;
				end else begin
					busy <= 1'b1;
					col  <= curCol + 1'b1;    // Column runs fastest
					row  <= curRow;
				end
			end
		end
	end

endmodule

// File: src/spriteTop.sv
// Sprite mover top level; direction switches in, framebuffer pixel-write strobe out
module spriteTop import spritePkg::*; #(
	parameter int TICK_DIV = 6_500_000    // Clocks per movement tick
) (
	input  logic       CLOCK_50,
	input  logic       resetn,
	input  logic [3:0] direction,
	output xCoordT     pixelX,
	output yCoordT     pixelY,
	output colourT     pixelColour,
	output logic       plot
);

	logic   tick;
	logic   step;
	dirT    stepDir;
	xCoordT posX;
	yCoordT posY;

	scanIf scanBus ();

	// Corner feeds the scan request
	assign scanBus.baseX = posX;
	assign scanBus.baseY = posY;

	//**********************************************************************
	// Instances
	//**********************************************************************
	moveTimer #(
		.TICK_DIV (TICK_DIV)
	) timer (
		.CLOCK_50 (CLOCK_50),
		.resetn   (resetn),
		.tick     (tick)
	);

	spriteFsm fsm (
		.CLOCK_50  (CLOCK_50),
		.resetn    (resetn),
		.tick      (tick),
		.direction (direction),
		.scan      (scanBus.fsm),
		.step      (step),
		.stepDir   (stepDir)
	);

	spritePosition position (
		.CLOCK_50 (CLOCK_50),
		.resetn   (resetn),
		.step     (step),
		.stepDir  (stepDir),
		.posX     (posX),
		.posY     (posY)
	);

	spriteScanner scanner (
		.CLOCK_50    (CLOCK_50),
		.resetn      (resetn),
		.scan        (scanBus.scanner),
		.pixelX      (pixelX),
		.pixelY      (pixelY),
		.pixelColour (pixelColour),
		.plot        (plot)
	);

endmodule

// File: test/spriteTop_sva.sv
// Concurrent checks on the pixel-write port; bound into spriteTop by the testbench
module spriteTopSva import spritePkg::*; (
	input logic   CLOCK_50,
	input logic   resetn,
	input xCoordT pixelX,
	input yCoordT pixelY,
	input logic   plot
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned failures;     // Failed assertions, watched by the testbench
	int unsigned runLength;    // Consecutive plot cycles up to the last edge

	initial failures = 0;

	// Length of the current write burst
	always_ff @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn) begin
			runLength <= 0;
		end else begin
			runLength <= plot ? runLength + 1 : 0;
		end
	end

	//**********************************************************************
	// Pixel port properties
	//**********************************************************************
	onScreen: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		plot |-> (int'(pixelX) < SCREEN_W) && (int'(pixelY) < SCREEN_H))
		else begin
			failures++;
			$error("pixel write outside the framebuffer");
		end

	// A burst never outgrows one pass
	burstNotLong: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		plot |-> (runLength < PIXEL_COUNT))
		else begin
			failures++;
			$error("plot high for more than one pass");
		end

	burstFull: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		$fell(plot) |-> (runLength == PIXEL_COUNT))
		else begin
			failures++;
			$error("plot burst ended before a full pass");
		end

	quietInReset: assert property (@(posedge CLOCK_50) !resetn |-> !plot)
		else begin
			failures++;
			$error("plot high during reset");
		end

endmodule

// File: test/spriteTb.sv
// Directed testbench for the sprite mover; checks every pixel pass against a corner model
module spriteTb import spritePkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TICK_DIV   = 400;             // Short tick period
	localparam int WAIT_LIMIT = 3 * TICK_DIV;

	logic       CLOCK_50;
	logic       resetn;
	logic [3:0] direction;
	xCoordT     pixelX;
	yCoordT     pixelY;
	colourT     pixelColour;
	logic       plot;

	int     cycleCount;    // Clocks since reset release
	int     modelX;        // Reference corner
	int     modelY;
	xCoordT gotX [PIXEL_COUNT];
	yCoordT gotY [PIXEL_COUNT];
	colourT gotColour [PIXEL_COUNT];

	spriteTop #(
		.TICK_DIV (TICK_DIV)
	) uut (
		.CLOCK_50    (CLOCK_50),
		.resetn      (resetn),
		.direction   (direction),
		.pixelX      (pixelX),
		.pixelY      (pixelY),
		.pixelColour (pixelColour),
		.plot        (plot)
	);

	bind spriteTop spriteTopSva props (
		.CLOCK_50 (CLOCK_50),
		.resetn   (resetn),
		.pixelX   (pixelX),
		.pixelY   (pixelY),
		.plot     (plot)
	);

	initial CLOCK_50 = 1'b0;
	always #4 CLOCK_50 = ~CLOCK_50;    // 8 ns period

	// Ticks fall where cycleCount is a multiple of TICK_DIV
	always @(posedge CLOCK_50 or negedge resetn) begin
		if (!resetn) cycleCount <= 0;
		else cycleCount <= cycleCount + 1;
	end

	always @(negedge CLOCK_50) begin
		if (uut.props.failures != 0) reportFailure("a concurrent assertion failed");
	end

	//**********************************************************************
	// Reporting and compare tasks
	//**********************************************************************
	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic checkCoord(input int idx, input xCoordT expX, input xCoordT actX,
		input yCoordT expY, input yCoordT actY);
		if (actX !== expX)
			reportFailure($sformatf("Fail pixelX pixel %0d expected 0x%h actual 0x%h",
				idx, expX, actX));
		if (actY !== expY)
			reportFailure($sformatf("Fail pixelY pixel %0d expected 0x%h actual 0x%h",
				idx, expY, actY));
	endtask

	task automatic checkColour(input int idx, input colourT expC, input colourT actC);
		if (actC !== expC)
			reportFailure($sformatf("Fail pixelColour pixel %0d expected 0x%h actual 0x%h",
				idx, expC, actC));
	endtask

	task automatic checkQuiet(input int cycles, input string window);
		for (int n = 0; n < cycles; n++) begin
			@(negedge CLOCK_50);
			if (plot !== 1'b0) reportFailure($sformatf("plot rose during %s", window));
		end
	endtask

	//**********************************************************************
	// Stimulus and reference model
	//**********************************************************************
	task automatic setDirection(input logic [3:0] value);
		@(posedge CLOCK_50);
		#1;    // Drive just after the edge
		direction = value;
	endtask

	task automatic waitPhase(input int phase);
		logic hit;
		hit = 1'b0;
		for (int n = 0; n <= TICK_DIV && !hit; n++) begin
			@(posedge CLOCK_50);
			#1;
			hit = ((cycleCount % TICK_DIV) == phase);
		end
		if (!hit) reportFailure("timed out waiting for a point in the tick period");
	endtask

	// Waits for plot, then records one whole pass
	task automatic collectPass();
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
			@(negedge CLOCK_50);
			seen = (plot === 1'b1);
		end
		if (!seen) reportFailure("timed out waiting for a pixel pass");
		for (int i = 0; i < PIXEL_COUNT; i++) begin
			if (i > 0) @(negedge CLOCK_50);
			if (plot !== 1'b1)
				reportFailure($sformatf("plot dropped after %0d pixels of a pass", i));
			gotX[i]      = pixelX;
			gotY[i]      = pixelY;
			gotColour[i] = pixelColour;
		end
	endtask

	function automatic colourT expectedColour(input logic erase, input int row, input int col);
		if (erase) return COLOUR_BLACK;
		if (col < spriteRowSpan[row].firstCol || col > spriteRowSpan[row].lastCol)
			return COLOUR_BLACK;    // Corner of the box outside the disc
		return COLOUR_SPRITE;
	endfunction

	task automatic verifyPass(input logic erase);
		int idx;
		for (int r = 0; r < SPRITE_SIZE; r++) begin
			for (int c = 0; c < SPRITE_SIZE; c++) begin
				idx = r * SPRITE_SIZE + c;    // Row-major, column fastest
				checkCoord(idx, xCoordT'(modelX + c), gotX[idx], yCoordT'(modelY + r), gotY[idx]);
				checkColour(idx, expectedColour(erase, r, c), gotColour[idx]);
			end
		end
	endtask

	task automatic moveModel(input logic [3:0] value);
		case (value)
			4'b0001: if (modelX < MAX_X) modelX++;
			4'b0010: if (modelY > 0) modelY--;
			4'b0100: if (modelY < MAX_Y) modelY++;
			4'b1000: if (modelX > 0) modelX--;
			default: ;
		endcase
	endtask

	// Direction held for count ticks, released after the last redraw
	task automatic moveSequence(input logic [3:0] value, input int count);
		setDirection(value);
		for (int k = 0; k < count; k++) begin
			collectPass();
			verifyPass(1'b1);    // Old corner
			moveModel(value);
			collectPass();
			verifyPass(1'b0);
		end
		setDirection(4'b0000);
	endtask

	//**********************************************************************
	// Directed tests
	//**********************************************************************
	task automatic testReset();
		checkQuiet(10, "reset");
		@(posedge CLOCK_50);
		#1;
		resetn = 1'b1;
		modelX = START_X;
		modelY = START_Y;
		collectPass();
		verifyPass(1'b1);    // Clear pass
		collectPass();
		verifyPass(1'b0);
	endtask

	task automatic testIdleDirections();
		logic [3:0] idleValues [3] = '{4'b0000, 4'b0011, 4'b1010};
		foreach (idleValues[i]) begin
			setDirection(idleValues[i]);
			checkQuiet(3 * TICK_DIV, "an idle direction setting");
		end
		setDirection(4'b0000);
	endtask

	task automatic testSingleMoves();
		logic [3:0] moves [4] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000};
		foreach (moves[i]) moveSequence(moves[i], 1);
	endtask

	task automatic testEdges();
		moveSequence(4'b1000, 70);    // Runs into x = 0
		moveSequence(4'b0010, 70);    // Runs into y = 0
	endtask

	task automatic testShortPulses();
		waitPhase(20);    // Just past a tick
		direction = 4'b0001;
		checkQuiet(100, "a direction cleared before the tick");
		setDirection(4'b0100);
		checkQuiet(100, "a direction cleared before the tick");
		setDirection(4'b0000);
		checkQuiet(TICK_DIV, "a tick with no direction");
	endtask

	initial begin
		resetn    = 1'b0;
		direction = 4'b0000;
		testReset();
		testIdleDirections();
		testSingleMoves();
		testEdges();
		testShortPulses();
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: compile.f
src/spritePkg.sv
src/scanIf.sv
src/moveTimer.sv
src/spriteFsm.sv
src/spritePosition.sv
src/spriteScanner.sv
src/spriteTop.sv
test/spriteTop_sva.sv
test/spriteTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= spriteTb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean
